// File: filelist.f
+incdir+.
rv_core_pkg.sv
rv_regfile.sv
rv_instr_queue.sv
rv_decoder.sv
rv_alu.sv
rv_writeback_stage.sv
rv_exec_core.sv
tb_rv_exec_core.sv

// File: Bender.yml
package:
  name: rv_exec_core

export_include_dirs:
  - .

sources:
  - rv_core_pkg.sv
  - rv_regfile.sv
  - rv_instr_queue.sv
  - rv_decoder.sv
  - rv_alu.sv
  - rv_writeback_stage.sv
  - rv_exec_core.sv
  - target: simulation
    files:
      - tb_rv_exec_core.sv

// File: tb_rv_exec_core.sv
`default_nettype none

`include "rv_core_defines.svh"

module tb_rv_exec_core;

  import rv_core_pkg::*;

  localparam int N_RANDOM = 400;
  localparam int TIMEOUT  = 200;

  logic        clk = 1'b0;
  logic        arst_n;
  logic        in_valid;
  logic [31:0] in_instr;
  logic        in_credit;
  logic        res_valid;
  result_t     res;
  logic        res_credit;

  logic [`RV_XLEN-1:0] model_regs [`RV_NREGS];
  result_t             exp_q [$];
  logic [31:0]         drv_rng;
  logic [31:0]         cred_rng;
  int up_credits;
  int pending;
  int sent;
  int received;
  int credit_pulses;
  int mismatches;
  int failures;
  int cycle;
  bit aborted;

  rv_exec_core dut0 (
    .clk        (clk),
    .arst_n     (arst_n),
    .in_valid   (in_valid),
    .in_instr   (in_instr),
    .in_credit  (in_credit),
    .res_valid  (res_valid),
    .res        (res),
    .res_credit (res_credit)
  );

  always #50 clk = ~clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic check_value(input string name, input logic [63:0] exp,
                             input logic [63:0] act);
    if (exp !== act) begin
      mismatches++;
      $display("** Error %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  // reference model run in send order.
  task automatic model_exec(input logic [31:0] w, output result_t r);
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] y;
    logic [2:0]  f3;
    logic        is_op;
    logic        ok;
    a     = model_regs[w[19:15]];
    f3    = w[14:12];
    is_op = w[6:0] == 7'h33;
    b     = is_op ? model_regs[w[24:20]] : {{52{w[31]}}, w[31:20]};
    y     = '0;
    ok    = 1'b1;
    if (w[6:0] == 7'h37) begin
      y = {{32{w[31]}}, w[31:12], 12'h000};
    end else if (is_op || w[6:0] == 7'h13) begin
      if (is_op) begin
        ok = (w[31:25] == 7'h00) || (w[31:25] == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
      end else if (f3 == 3'd1) begin
        ok = w[31:26] == 6'h00;
      end else if (f3 == 3'd5) begin
        ok = (w[31:26] == 6'h00) || (w[31:26] == 6'h10);
      end
      case (f3)
        3'd0: y = (is_op && w[30]) ? a - b : a + b;
        3'd1: y = a << b[5:0];
        3'd2: y = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
        3'd3: y = (a < b) ? 64'd1 : 64'd0;
        3'd4: y = a ^ b;
        3'd5: begin
          if (w[30]) y = $signed(a) >>> b[5:0];
          else y = a >> b[5:0];
        end
        3'd6: y = a | b;
        default: y = a & b;
      endcase
    end else begin
      ok = 1'b0;
    end
    if (ok && w[11:7] != 5'd0) model_regs[w[11:7]] = y;
    r.rd      = w[11:7];
    r.value   = y;
    r.illegal = !ok;
  endtask

  // mostly legal words biased towards x0..x7 so results feed each other.
  function automatic logic [31:0] make_instr(input logic [31:0] r, input logic [31:0] s);
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [6:0]  f7;
    rd  = r[8] ? {2'b00, r[2:0]} : r[7:3];
    rs1 = s[8] ? {2'b00, s[2:0]} : s[7:3];
    rs2 = r[20] ? {2'b00, r[11:9]} : r[16:12];
    f3  = s[11:9];
    f7  = (s[24] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00;
    case (r[31:28])
      4'd0: return {s[31:7], 7'b1110011};
      4'd1: return {7'h01, rs2, rs1, f3, rd, 7'h33};
      4'd2: return {s[23:18] | 6'h01, s[17:12], rs1, 3'b001, rd, 7'h13};
      4'd3, 4'd4: return {s[31:12], rd, 7'h37};
      4'd5, 4'd6, 4'd7, 4'd8, 4'd9: return {f7, rs2, rs1, f3, rd, 7'h33};
      default: begin
        if (f3 == 3'd1 || f3 == 3'd5) return {f7[6:1], s[17:12], rs1, f3, rd, 7'h13};
        else return {s[23:12], rs1, f3, rd, 7'h13};
      end
    endcase
  endfunction

  task automatic send_instr(input logic [31:0] word);
    result_t want;
    int      waited;
    waited = 0;
    @(negedge clk);
    in_valid = 1'b0;
    while (up_credits == 0 && waited < TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (up_credits == 0) begin
      $display("timed out waiting for an input credit after %0d sent", sent);
      failures++;
      aborted = 1'b1;
    end else begin
      in_valid = 1'b1;
      in_instr = word;
      up_credits--;
      model_exec(word, want);
      exp_q.push_back(want);
      sent++;
    end
  endtask

  always @(posedge clk) begin : monitor
    result_t want;
    if (in_credit) begin
      up_credits++;
      credit_pulses++;
    end
    if (res_valid) begin
      received++;
      pending++;
      if (exp_q.size() == 0) begin
        $display("result arrived with no instruction outstanding");
        failures++;
      end else begin
        want = exp_q.pop_front();
        check_value($sformatf("result %0d rd", received), want.rd, res.rd);
        check_value($sformatf("result %0d illegal", received), want.illegal, res.illegal);
        if (!want.illegal) begin
          check_value($sformatf("result %0d value", received), want.value, res.value);
        end
      end
    end
    check_value("outstanding results within credits", 1, pending <= `RV_OUT_CREDITS);
  end

  // downstream consumer that withholds all credits for a while.
  always @(negedge clk) begin
    cycle++;
    res_credit = 1'b0;
    if (pending > 0 && !(cycle >= 300 && cycle < 360)) begin
      cred_rng = lcg_next(cred_rng);
      if (cred_rng[16]) begin
        res_credit = 1'b1;
        pending--;
      end
    end
  end

  initial begin
    logic [31:0] r;
    int          waited;
    arst_n     = 1'b0;
    in_valid   = 1'b0;
    in_instr   = '0;
    res_credit = 1'b0;
    drv_rng    = 32'h5a9f2fb6;
    cred_rng   = 32'h5a9f2fb6 ^ 32'h3c6ef372;
    up_credits = `RV_IQ_DEPTH;
    for (int i = 0; i < `RV_NREGS; i++) model_regs[i] = '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);
    check_value("in_credit after reset", 0, in_credit);
    check_value("res_valid after reset", 0, res_valid);
    // addi xi, xi, 0 reads every register once.
    for (int i = 0; i < `RV_NREGS && !aborted; i++) begin
      send_instr({12'h000, 5'(i), 3'b000, 5'(i), 7'h13});
    end
    send_instr({20'hfffff, 5'd0, 7'h37});
    send_instr({12'h000, 5'd0, 3'b000, 5'd6, 7'h13});
    for (int n = 0; n < N_RANDOM && !aborted; n++) begin
      drv_rng = lcg_next(drv_rng);
      r       = drv_rng;
      drv_rng = lcg_next(drv_rng);
      repeat (drv_rng[1:0] == 2'b00 ? drv_rng[3:2] : 0) begin
        @(negedge clk);
        in_valid = 1'b0;
      end
      send_instr(make_instr(r, drv_rng));
    end
    @(negedge clk);
    in_valid = 1'b0;
    waited   = 0;
    while ((received < sent || pending > 0) && waited < 2000) begin
      @(negedge clk);
      waited++;
    end
    if (received < sent || pending > 0) begin
      $display("timed out waiting for the result stream to drain");
      failures++;
    end
    check_value("results received", sent, received);
    check_value("in_credit pulses", sent, credit_pulses);
    check_value("expected results left", 0, exp_q.size());
    $display("sent %0d, received %0d, mismatches %0d, other failures %0d",
             sent, received, mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: rv_exec_core.sv
`default_nettype none

`include "rv_core_defines.svh"

module rv_exec_core (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 in_valid,
  input  logic [31:0]          in_instr,
  output logic                 in_credit,
  output logic                 res_valid,
  output rv_core_pkg::result_t res,
  input  logic                 res_credit
);

  import rv_core_pkg::*;

  logic [31:0]         head_instr;
  logic                not_empty;
  logic                pop;
  logic                rf_we;
  decoded_t            dec;
  logic [`RV_XLEN-1:0] rs1_data;
  logic [`RV_XLEN-1:0] rs2_data;
  logic [`RV_XLEN-1:0] alu_b;
  logic [`RV_XLEN-1:0] alu_y;

  rv_instr_queue u_queue (
    .clk        (clk),
    .arst_n     (arst_n),
    .in_valid   (in_valid),
    .in_instr   (in_instr),
    .pop        (pop),
    .head_instr (head_instr),
    .not_empty  (not_empty),
    .in_credit  (in_credit)
  );

  rv_decoder u_decoder (
    .instr (head_instr),
    .dec   (dec)
  );

  rv_regfile u_regfile (
    .clk    (clk),
    .arst_n (arst_n),
    .we     (rf_we),
    .waddr  (dec.rd),
    .wdata  (alu_y),
    .raddr1 (dec.rs1),
    .raddr2 (dec.rs2),
    .rdata1 (rs1_data),
    .rdata2 (rs2_data)
  );

  // immediate forms replace the rs2 operand.
  assign alu_b = dec.use_imm ? dec.imm : rs2_data;

  rv_alu u_alu (
    .op (dec.alu_op),
    .a  (rs1_data),
    .b  (alu_b),
    .y  (alu_y)
  );

  rv_writeback_stage u_writeback (
    .clk        (clk),
    .arst_n     (arst_n),
    .not_empty  (not_empty),
    .dec        (dec),
    .alu_y      (alu_y),
    .res_credit (res_credit),
    .pop        (pop),
    .rf_we      (rf_we),
    .res_valid  (res_valid),
    .res        (res)
  );

endmodule

`default_nettype wire

// File: rv_writeback_stage.sv
`default_nettype none

`include "rv_core_defines.svh"

module rv_writeback_stage (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  not_empty,
  input  rv_core_pkg::decoded_t dec,
  input  logic [`RV_XLEN-1:0]   alu_y,
  input  logic                  res_credit,
  output logic                  pop,
  output logic                  rf_we,
  output logic                  res_valid,
  output rv_core_pkg::result_t  res
);

  import rv_core_pkg::*;

  localparam int CW = $clog2(`RV_OUT_CREDITS + 1);

  logic [CW-1:0] credits;

  // issue only when a result slot is free downstream.
  assign pop   = not_empty && (credits != '0);
  assign rf_we = pop && dec.we && !dec.illegal;

  // a send and a returned credit may land on the same edge.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      credits   <= CW'(`RV_OUT_CREDITS);
      res_valid <= 1'b0;
    end else begin
      credits   <= credits + CW'(res_credit) - CW'(pop);
      res_valid <= pop;
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      res.rd      <= dec.rd;
      res.value   <= alu_y;
      res.illegal <= dec.illegal;
    end
  end

  // downstream returned more credits than it was given.
  credit_bound: assert property (
    @(posedge clk) disable iff (!arst_n)
    credits <= CW'(`RV_OUT_CREDITS)
  ) else $error("result credit counter above its initial value");

endmodule

`default_nettype wire

// File: rv_alu.sv
`default_nettype none

`include "rv_core_defines.svh"

module rv_alu (
  input  rv_core_pkg::alu_op_e  op,
  input  logic [`RV_XLEN-1:0]   a,
  input  logic [`RV_XLEN-1:0]   b,
  output logic [`RV_XLEN-1:0]   y
);

  import rv_core_pkg::*;

  logic [5:0] shamt;
  logic       lt_s;
  logic       lt_u;

  // rv64 shifts use six bits of the amount.
  assign shamt = b[5:0];
  assign lt_s  = $signed(a) < $signed(b);
  assign lt_u  = a < b;

  always_comb begin
    case (op)
      alu_add:    y = a + b;
      alu_sub:    y = a - b;
      alu_sll:    y = a << shamt;
      alu_slt:    y = {{(`RV_XLEN-1){1'b0}}, lt_s};
      alu_sltu:   y = {{(`RV_XLEN-1){1'b0}}, lt_u};
      alu_xor:    y = a ^ b;
      alu_srl:    y = a >> shamt;
      alu_sra:    y = $unsigned($signed(a) >>> shamt);
      alu_or:     y = a | b;
      alu_and:    y = a & b;
      alu_pass_b: y = b;
      default:    y = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: rv_decoder.sv
`default_nettype none

`include "rv_core_defines.svh"

module rv_decoder (
  input  logic [31:0]           instr,
  output rv_core_pkg::decoded_t dec
);

  import rv_core_pkg::*;

  opcode_e             opc;
  logic [2:0]          funct3;
  logic [6:0]          funct7;
  logic [`RV_XLEN-1:0] imm_i;
  logic [`RV_XLEN-1:0] imm_u;

  assign opc    = opcode_e'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign imm_i  = {{(`RV_XLEN-12){instr[31]}}, instr[31:20]};
  assign imm_u  = {{(`RV_XLEN-32){instr[31]}}, instr[31:12], 12'b0};

  always_comb begin
    dec         = '0;
    dec.rs1     = instr[19:15];
    dec.rs2     = instr[24:20];
    dec.rd      = instr[11:7];
    dec.alu_op  = alu_add;
    dec.we      = 1'b1;
    case (opc)
      opc_op: begin
        case ({funct7, funct3})
          10'b0000000_000: dec.alu_op = alu_add;
          10'b0100000_000: dec.alu_op = alu_sub;
          10'b0000000_001: dec.alu_op = alu_sll;
          10'b0000000_010: dec.alu_op = alu_slt;
          10'b0000000_011: dec.alu_op = alu_sltu;
          10'b0000000_100: dec.alu_op = alu_xor;
          10'b0000000_101: dec.alu_op = alu_srl;
          10'b0100000_101: dec.alu_op = alu_sra;
          10'b0000000_110: dec.alu_op = alu_or;
          10'b0000000_111: dec.alu_op = alu_and;
          default:         dec.illegal = 1'b1;
        endcase
      end
      opc_op_imm: begin
        dec.imm     = imm_i;
        dec.use_imm = 1'b1;
        case (funct3)
          3'b000: dec.alu_op = alu_add;
          3'b010: dec.alu_op = alu_slt;
          3'b011: dec.alu_op = alu_sltu;
          3'b100: dec.alu_op = alu_xor;
          3'b110: dec.alu_op = alu_or;
          3'b111: dec.alu_op = alu_and;
          // shifts take imm[5:0]; the upper six bits pick the kind.
          3'b001: begin
            if (instr[31:26] == 6'b000000) dec.alu_op = alu_sll;
            else dec.illegal = 1'b1;
          end
          default: begin
            if (instr[31:26] == 6'b000000) dec.alu_op = alu_srl;
            else if (instr[31:26] == 6'b010000) dec.alu_op = alu_sra;
            else dec.illegal = 1'b1;
          end
        endcase
      end
      opc_lui: begin
        dec.imm     = imm_u;
        dec.use_imm = 1'b1;
        dec.alu_op  = alu_pass_b;
      end
      default: dec.illegal = 1'b1;
    endcase
    // illegal words must not touch the register file.
    if (dec.illegal) begin
      dec.we = 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: rv_instr_queue.sv
`default_nettype none

`include "rv_core_defines.svh"

module rv_instr_queue (
  input  logic        clk,
  input  logic        arst_n,
  input  logic        in_valid,
  input  logic [31:0] in_instr,
  input  logic        pop,
  output logic [31:0] head_instr,
  output logic        not_empty,
  output logic        in_credit
);

  localparam int PW = $clog2(`RV_IQ_DEPTH);
  localparam int CW = PW + 1;

  logic [31:0]   mem [`RV_IQ_DEPTH];
  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic [CW-1:0] count;
  logic          full;

  assign full       = count == CW'(`RV_IQ_DEPTH);
  assign not_empty  = count != '0;
  assign head_instr = mem[rd_ptr];

  // one credit back upstream for every entry freed.
  assign in_credit = pop;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (in_valid) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + CW'(in_valid) - CW'(pop);
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      mem[wr_ptr] <= in_instr;
    end
  end

  // sender spent a credit it did not hold.
  no_push_full: assert property (
    @(posedge clk) disable iff (!arst_n)
    !(in_valid && full)
  ) else $error("instruction pushed into a full queue");

  no_pop_empty: assert property (
    @(posedge clk) disable iff (!arst_n)
    !(pop && !not_empty)
  ) else $error("pop from an empty queue");

endmodule

`default_nettype wire

// File: rv_regfile.sv
`default_nettype none

`include "rv_core_defines.svh"

module rv_regfile (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                we,
  input  logic [4:0]          waddr,
  input  logic [`RV_XLEN-1:0] wdata,
  input  logic [4:0]          raddr1,
  input  logic [4:0]          raddr2,
  output logic [`RV_XLEN-1:0] rdata1,
  output logic [`RV_XLEN-1:0] rdata2
);

  logic [`RV_XLEN-1:0] regs [`RV_NREGS];

  // x0 is never written, so it keeps its reset value.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `RV_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (waddr != 5'd0)) begin
      regs[waddr] <= wdata;
    end
  end

  // combinational reads.
  assign rdata1 = regs[raddr1];
  assign rdata2 = regs[raddr2];

  // x0 must read zero no matter what was written.
  x0_zero: assert property (
    @(posedge clk) disable iff (!arst_n)
    regs[0] == '0
  ) else $error("x0 holds a nonzero value");

endmodule

`default_nettype wire

// File: rv_core_pkg.sv
`default_nettype none

`include "rv_core_defines.svh"

package rv_core_pkg;

  // major opcodes, low 7 bits of the instruction word.
  typedef enum logic [6:0] {
    opc_op     = 7'b0110011,
    opc_op_imm = 7'b0010011,
    opc_lui    = 7'b0110111
  } opcode_e;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b
  } alu_op_e;

  typedef struct packed {
    alu_op_e             alu_op;
    logic [4:0]          rs1;
    logic [4:0]          rs2;
    logic [4:0]          rd;
    logic [`RV_XLEN-1:0] imm;
    logic                use_imm;
    logic                we;
    logic                illegal;
  } decoded_t;

  // record handed to the downstream consumer.
  typedef struct packed {
    logic [4:0]          rd;
    logic [`RV_XLEN-1:0] value;
    logic                illegal;
  } result_t;

endpackage

`default_nettype wire

// File: rv_core_defines.svh
`ifndef RV_CORE_DEFINES_SVH
`define RV_CORE_DEFINES_SVH

// datapath width.
`define RV_XLEN 64

// architectural registers, 5-bit addresses.
`define RV_NREGS 32

// input queue entries.
// upstream holds this many credits after reset.
`define RV_IQ_DEPTH 4

// result credits held by the core after reset.
`define RV_OUT_CREDITS 2

`endif
